//--- bench/core_assertions.sv
`timescale 1ns/100ps

module core_assertions import core_pkg::*; (
	input logic     clock,
	input logic     reset,
	input logic     imem_valid_o,
	input mem_req_t imem_req_o,
	input logic     imem_ready_i,
	input logic     dmem_valid_o,
	input mem_req_t dmem_req_o,
	input logic     dmem_ready_i
);
	// request held until the memory takes it
	a_imem_hold: assert property (@(posedge clock) disable iff (reset)
		imem_valid_o && !imem_ready_i |=> imem_valid_o && $stable(imem_req_o))
		else $error("imem request changed or dropped before ready");

	a_dmem_hold: assert property (@(posedge clock) disable iff (reset)
		dmem_valid_o && !dmem_ready_i |=> dmem_valid_o && $stable(dmem_req_o))
		else $error("dmem request changed or dropped before ready");

	// valid drops right after the transfer
	a_imem_drop: assert property (@(posedge clock) disable iff (reset)
		imem_valid_o && imem_ready_i |=> !imem_valid_o)
		else $error("imem valid still high after the transfer");

	a_dmem_drop: assert property (@(posedge clock) disable iff (reset)
		dmem_valid_o && dmem_ready_i |=> !dmem_valid_o)
		else $error("dmem valid still high after the transfer");

	a_one_port: assert property (@(posedge clock) disable iff (reset)
		!(imem_valid_o && dmem_valid_o))
		else $error("imem and dmem valid together");

	a_reset_quiet: assert property (@(posedge clock)
		reset |=> !imem_valid_o && !dmem_valid_o)
		else $error("memory valid high during reset");

endmodule

bind core_top core_assertions i_assertions (
	.clock(clock), .reset(reset),
	.imem_valid_o(imem_valid_o), .imem_req_o(imem_req_o), .imem_ready_i(imem_ready_i),
	.dmem_valid_o(dmem_valid_o), .dmem_req_o(dmem_req_o), .dmem_ready_i(dmem_ready_i)
);

//--- bench/core_tb.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module core_tb import core_pkg::*; ();
	localparam int HALT_IDX  = 232;
	localparam int DUMP_WORD = 384; // byte address 0x600

	logic                  clock;
	logic                  reset;
	logic                  imem_valid, imem_ready;
	logic                  dmem_valid, dmem_ready;
	mem_req_t              imem_req, dmem_req;
	logic [`CORE_XLEN-1:0] imem_rdata, dmem_rdata;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:1023];
	logic [31:0] model_mem [0:1023];
	logic [31:0] model_regs [0:31];
	logic [31:0] model_pc;
	logic [31:0] lfsr;

	core_top i_dut (
		.clock(clock), .reset(reset),
		.imem_valid_o(imem_valid), .imem_req_o(imem_req),
		.imem_ready_i(imem_ready), .imem_rdata_i(imem_rdata),
		.dmem_valid_o(dmem_valid), .dmem_req_o(dmem_req),
		.dmem_ready_i(dmem_ready), .dmem_rdata_i(dmem_rdata)
	);

	always #10 clock = ~clock;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] store_word(logic [4:0] rs2, logic [11:0] off);
		return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], OP_STORE}; // sw rs2, off(x0)
	endfunction

	function automatic logic [31:0] gen_inst(int i);
		logic [31:0] r1, r2;
		logic [4:0]  rd, rs1, rs2;
		logic [2:0]  f3;
		logic [11:0] imm, moff, tgt;
		logic [12:0] boff;
		logic [20:0] joff;
		logic [6:0]  f7;
		int          off;
		r1 = rand_bits(32);
		r2 = rand_bits(32);
		rd = r1[8:4];
		rs1 = r1[13:9];
		rs2 = r1[18:14];
		f3 = r1[21:19];
		off = 1 + r1[24:22];
		if (i + off > 200)
			off = 200 - i; // forward and never past the dump
		boff = 13'(off * 4);
		joff = 21'(off * 4);
		tgt = 12'((i + off) * 4);
		moff = 12'h400 + {6'b0, r1[29:26], 2'b0};
		imm = r2[31:20];
		f7 = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r1[25], 5'b0} : 7'b0;
		if (i == 0)
			return {r2[19:0], 5'd0, OP_LUI}; // write to x0
		case (r1[3:0])
			4'd0: return {r2[19:0], rd, OP_LUI};
			4'd1: return {r2[19:0], rd, OP_AUIPC};
			4'd2: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, OP_JAL};
			4'd3: return {tgt, 5'd0, 3'b000, rd, OP_JALR};
			4'd4, 4'd5: begin
				if (f3[2:1] == 2'b01)
					f3[2] = 1'b1; // no branch at 010 and 011
				return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OP_BRANCH};
			end
			4'd6: return {moff, 5'd0, 3'b010, rd, OP_LOAD};
			4'd7: return store_word(rs2, moff);
			4'd8, 4'd9, 4'd10, 4'd11: begin
				if (f3 == 3'b001 || f3 == 3'b101)
					imm[11:5] = f7; // shamt form
				return {imm, rs1, f3, rd, OP_IMM};
			end
			default: return {f7, rs2, rs1, f3, rd, OP_OP};
		endcase
	endfunction

	task automatic load_program();
		for (int k = 0; k < 256; k++)
			imem[k] = '0;
		for (int k = 0; k < 1024; k++)
			dmem[k] = '0;
		for (int k = 0; k < 16; k++)
			dmem[256 + k] = rand_bits(32); // data window at 0x400
		for (int k = 0; k < 1024; k++)
			model_mem[k] = dmem[k];
		for (int k = 0; k < 200; k++)
			imem[k] = gen_inst(k);
		for (int r = 1; r < 32; r++)
			imem[199 + r] = store_word(5'(r), 12'(1536 + 4 * r));
		imem[231] = store_word(5'd0, 12'h600);
		imem[HALT_IDX] = {20'b0, 5'd0, OP_JAL}; // jal x0, 0
	endtask

	function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a, b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// one instruction of the reference interpreter
	task automatic model_step(input logic [31:0] w, output logic mem, output logic wen,
		output logic [31:0] addr, output logic [31:0] wdata);
		logic [31:0] a, b, res, npc;
		logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
		logic [2:0]  f3;
		logic        wr, taken;
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		f3 = w[14:12];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'b0};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		npc = model_pc + 32'd4;
		res = '0;
		wr = 1'b1;
		mem = 1'b0;
		wen = 1'b0;
		addr = '0;
		wdata = '0;
		taken = 1'b0;
		case (w[6:0])
			OP_LUI:   res = imm_u;
			OP_AUIPC: res = model_pc + imm_u;
			OP_JAL: begin
				res = model_pc + 32'd4;
				npc = model_pc + imm_j;
			end
			OP_JALR: begin
				res = model_pc + 32'd4;
				npc = (a + imm_i) & ~32'd1;
			end
			OP_BRANCH: begin
				wr = 1'b0;
				case (f3)
					3'b000: taken = a == b;
					3'b001: taken = a != b;
					3'b100: taken = $signed(a) < $signed(b);
					3'b101: taken = $signed(a) >= $signed(b);
					3'b110: taken = a < b;
					3'b111: taken = a >= b;
					default: taken = 1'b0;
				endcase
				if (taken)
					npc = model_pc + imm_b;
			end
			OP_LOAD: begin
				mem = 1'b1;
				addr = a + imm_i;
				res = model_mem[addr[11:2]];
			end
			OP_STORE: begin
				wr = 1'b0;
				mem = 1'b1;
				wen = 1'b1;
				addr = a + imm_s;
				wdata = b;
				model_mem[addr[11:2]] = b;
			end
			OP_IMM: res = alu(f3, w[30] && f3 == 3'b101, a, imm_i);
			OP_OP:  res = alu(f3, w[30], a, b);
			default: wr = 1'b0; // unknown opcode retires as a no-op
		endcase
		if (wr && w[11:7] != 5'd0)
			model_regs[w[11:7]] = res;
		model_pc = npc;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic wait_valid(input logic data_port);
		int cycles;
		cycles = 0;
		while ((data_port ? dmem_valid : imem_valid) !== 1'b1) begin
			next_cycle();
			cycles++;
			if (cycles == 200) begin
				if (data_port)
					abort_run("timeout: no data memory request within 200 cycles");
				else
					abort_run("timeout: no instruction memory request within 200 cycles");
			end
		end
	endtask

	// ready after 0 to 3 wait cycles with data in the same cycle
	task automatic serve(input logic data_port, input logic [31:0] rdata);
		int delay;
		delay = rand_bits(2);
		repeat (delay) next_cycle();
		if (data_port) begin
			dmem_ready = 1'b1;
			dmem_rdata = rdata;
		end else begin
			imem_ready = 1'b1;
			imem_rdata = rdata;
		end
		next_cycle();
		imem_ready = 1'b0;
		dmem_ready = 1'b0;
	endtask

	initial begin
		logic        mem, wen, halted;
		logic [31:0] addr, wdata;
		clock = 1'b0;
		reset = 1'b1;
		imem_ready = 1'b0;
		imem_rdata = '0;
		dmem_ready = 1'b0;
		dmem_rdata = '0;
		lfsr = 32'h3c49a072;
		load_program();
		for (int k = 0; k < 32; k++)
			model_regs[k] = '0;
		model_pc = `CORE_RESET_PC;
		repeat (10) begin
			next_cycle();
			check("imem_valid_o", 32'(imem_valid), 32'd0);
			check("dmem_valid_o", 32'(dmem_valid), 32'd0);
		end
		reset = 1'b0;
		check("imem_valid_o", 32'(imem_valid), 32'd0);
		check("dmem_valid_o", 32'(dmem_valid), 32'd0);

		halted = 1'b0;
		while (!halted) begin
			wait_valid(1'b0);
			check("imem_req_o.addr", imem_req.addr, model_pc);
			check("imem_req_o.wen", 32'(imem_req.wen), 32'd0);
			serve(1'b0, imem[imem_req.addr[9:2]]);
			if (model_pc == 32'(HALT_IDX * 4)) begin
				halted = 1'b1;
			end else begin
				model_step(imem[model_pc[9:2]], mem, wen, addr, wdata);
				if (mem) begin
					wait_valid(1'b1);
					check("dmem_req_o.addr", dmem_req.addr, addr);
					check("dmem_req_o.wen", 32'(dmem_req.wen), 32'(wen));
					if (wen)
						check("dmem_req_o.wdata", dmem_req.wdata, wdata);
					if (dmem_req.wen)
						dmem[dmem_req.addr[11:2]] = dmem_req.wdata;
					serve(1'b1, dmem[dmem_req.addr[11:2]]);
				end
			end
		end

		// x0 dump must read zero
		for (int r = 0; r < 32; r++)
			check($sformatf("dump of x%0d", r), dmem[DUMP_WORD + r],
				(r == 0) ? 32'd0 : model_regs[r]);
		$display("Verification passed");
		$finish;
	end

endmodule

//--- build.f
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/exec_unit.sv
source/load_store_unit.sv
source/core_top.sv
bench/core_assertions.sv
bench/core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module core_tb

out=$(./obj_dir/Vcore_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Verification passed"

//--- source/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width
`define CORE_XLEN 32

// register index width
`define CORE_REG_ADDR_W 5

// architectural registers, x0 included
`define CORE_NUM_REGS 32

// first fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- source/core_pkg.sv
package core_pkg;

`include "core_defs.svh"

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, seen in every format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	typedef struct packed {
		alu_op_e                     alu_op;
		logic                        a_sel_pc;  // operand a from pc
		logic                        b_sel_imm; // operand b from imm
		logic                        is_branch;
		logic [2:0]                  funct3;
		logic                        is_jal;
		logic                        is_jalr;
		logic                        is_load;
		logic                        is_store;
		logic                        rd_wen;
		logic [`CORE_REG_ADDR_W-1:0] rd;
		logic [`CORE_XLEN-1:0]       imm;
		logic [`CORE_XLEN-1:0]       rs1_data;
		logic [`CORE_XLEN-1:0]       rs2_data;
		logic [`CORE_XLEN-1:0]       pc;
	} ctrl_t;

	typedef struct packed {
		logic [`CORE_XLEN-1:0]       alu_result; // also the data address
		logic [`CORE_XLEN-1:0]       store_data;
		logic [`CORE_XLEN-1:0]       link;
		logic [`CORE_XLEN-1:0]       next_pc;
		logic                        is_link;
		logic                        is_load;
		logic                        is_store;
		logic                        rd_wen;
		logic [`CORE_REG_ADDR_W-1:0] rd;
	} ex_result_t;

	typedef struct packed {
		logic                        wen;
		logic [`CORE_REG_ADDR_W-1:0] rd;
		logic [`CORE_XLEN-1:0]       data;
	} wb_t;

	typedef struct packed {
		logic [`CORE_XLEN-1:0] addr;
		logic [`CORE_XLEN-1:0] wdata;
		logic                  wen;
	} mem_req_t;

endpackage

//--- source/core_top.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module core_top import core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	output logic                  imem_valid_o,
	output mem_req_t              imem_req_o,
	input  logic                  imem_ready_i,
	input  logic [`CORE_XLEN-1:0] imem_rdata_i,
	output logic                  dmem_valid_o,
	output mem_req_t              dmem_req_o,
	input  logic                  dmem_ready_i,
	input  logic [`CORE_XLEN-1:0] dmem_rdata_i
);
	logic                        fetch_done;
	inst_u                       inst;
	logic [`CORE_XLEN-1:0]       fetch_pc;
	logic [`CORE_REG_ADDR_W-1:0] rs1_addr;
	logic [`CORE_REG_ADDR_W-1:0] rs2_addr;
	logic [`CORE_XLEN-1:0]       rs1_data;
	logic [`CORE_XLEN-1:0]       rs2_data;
	logic                        decode_done;
	ctrl_t                       ctrl;
	logic                        exec_done;
	ex_result_t                  ex_result;
	logic                        retire;
	logic [`CORE_XLEN-1:0]       next_pc;
	wb_t                         wb;

	fetch_unit i_fetch (
		.clock(clock), .reset(reset),
		.retire_i(retire), .next_pc_i(next_pc),
		.imem_valid_o(imem_valid_o), .imem_req_o(imem_req_o),
		.imem_ready_i(imem_ready_i), .imem_rdata_i(imem_rdata_i),
		.fetch_done_o(fetch_done), .inst_o(inst), .pc_o(fetch_pc)
	);

	decode_unit i_decode (
		.clock(clock), .reset(reset),
		.fetch_done_i(fetch_done), .inst_i(inst), .pc_i(fetch_pc),
		.rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
		.rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
		.decode_done_o(decode_done), .ctrl_o(ctrl)
	);

	reg_file i_regs (
		.clock(clock), .reset(reset),
		.rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
		.rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
		.wb_i(wb)
	);

	exec_unit i_exec (
		.clock(clock), .reset(reset),
		.decode_done_i(decode_done), .ctrl_i(ctrl),
		.exec_done_o(exec_done), .result_o(ex_result)
	);

	load_store_unit i_lsu (
		.clock(clock), .reset(reset),
		.exec_done_i(exec_done), .result_i(ex_result),
		.dmem_valid_o(dmem_valid_o), .dmem_req_o(dmem_req_o),
		.dmem_ready_i(dmem_ready_i), .dmem_rdata_i(dmem_rdata_i),
		.retire_o(retire), .next_pc_o(next_pc), .wb_o(wb)
	);

endmodule

//--- source/decode_unit.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module decode_unit import core_pkg::*; (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        fetch_done_i,
	input  inst_u                       inst_i,
	input  logic [`CORE_XLEN-1:0]       pc_i,
	output logic [`CORE_REG_ADDR_W-1:0] rs1_addr_o,
	output logic [`CORE_REG_ADDR_W-1:0] rs2_addr_o,
	input  logic [`CORE_XLEN-1:0]       rs1_data_i,
	input  logic [`CORE_XLEN-1:0]       rs2_data_i,
	output logic                        decode_done_o,
	output ctrl_t                       ctrl_o
);
	logic [`CORE_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic                  alt;
	alu_op_e               alu_f3;
	ctrl_t                 ctrl_d;
	ctrl_t                 ctrl_q;
	logic                  done_q;

	assign rs1_addr_o = inst_i.r.rs1;
	assign rs2_addr_o = inst_i.r.rs2;

	assign imm_i = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
	assign imm_s = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
	assign imm_b = {{20{inst_i.b.imm_12}}, inst_i.b.imm_11, inst_i.b.imm_10_5,
		inst_i.b.imm_4_1, 1'b0};
	assign imm_u = {inst_i.u.imm, 12'b0};
	assign imm_j = {{12{inst_i.j.imm_20}}, inst_i.j.imm_19_12, inst_i.j.imm_11,
		inst_i.j.imm_10_1, 1'b0};

	// sub only for register ops, sra for both shift forms
	assign alt = inst_i.r.funct7[5]
		& ((inst_i.r.opcode == OP_OP) | (inst_i.r.funct3 == 3'b101));

	always_comb begin
		case (inst_i.r.funct3)
			3'b000:  alu_f3 = alt ? ALU_SUB : ALU_ADD;
			3'b001:  alu_f3 = ALU_SLL;
			3'b010:  alu_f3 = ALU_SLT;
			3'b011:  alu_f3 = ALU_SLTU;
			3'b100:  alu_f3 = ALU_XOR;
			3'b101:  alu_f3 = alt ? ALU_SRA : ALU_SRL;
			3'b110:  alu_f3 = ALU_OR;
			default: alu_f3 = ALU_AND;
		endcase
	end

	always_comb begin
		ctrl_d          = '0; // no-op unless the opcode is known
		ctrl_d.alu_op   = ALU_ADD;
		ctrl_d.funct3   = inst_i.r.funct3;
		ctrl_d.rd       = inst_i.r.rd;
		ctrl_d.rs1_data = rs1_data_i;
		ctrl_d.rs2_data = rs2_data_i;
		ctrl_d.pc       = pc_i;
		case (inst_i.r.opcode)
			OP_LUI: begin
				ctrl_d.alu_op    = ALU_PASS_B;
				ctrl_d.b_sel_imm = 1'b1;
				ctrl_d.imm       = imm_u;
				ctrl_d.rd_wen    = 1'b1;
			end
			OP_AUIPC: begin
				ctrl_d.a_sel_pc  = 1'b1;
				ctrl_d.b_sel_imm = 1'b1;
				ctrl_d.imm       = imm_u;
				ctrl_d.rd_wen    = 1'b1;
			end
			OP_JAL: begin
				ctrl_d.is_jal = 1'b1;
				ctrl_d.imm    = imm_j;
				ctrl_d.rd_wen = 1'b1;
			end
			OP_JALR: begin
				ctrl_d.is_jalr   = 1'b1;
				ctrl_d.b_sel_imm = 1'b1; // alu forms rs1+imm
				ctrl_d.imm       = imm_i;
				ctrl_d.rd_wen    = 1'b1;
			end
			OP_BRANCH: begin
				ctrl_d.is_branch = 1'b1;
				ctrl_d.imm       = imm_b;
			end
			OP_LOAD: begin
				ctrl_d.is_load   = 1'b1;
				ctrl_d.b_sel_imm = 1'b1;
				ctrl_d.imm       = imm_i;
				ctrl_d.rd_wen    = 1'b1;
			end
			OP_STORE: begin
				ctrl_d.is_store  = 1'b1;
				ctrl_d.b_sel_imm = 1'b1;
				ctrl_d.imm       = imm_s;
			end
			OP_IMM: begin
				ctrl_d.alu_op    = alu_f3;
				ctrl_d.b_sel_imm = 1'b1;
				ctrl_d.imm       = imm_i;
				ctrl_d.rd_wen    = 1'b1;
			end
			OP_OP: begin
				ctrl_d.alu_op = alu_f3;
				ctrl_d.rd_wen = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			done_q <= 1'b0;
		else
			done_q <= fetch_done_i;
	end

	always_ff @(posedge clock) begin
		if (fetch_done_i)
			ctrl_q <= ctrl_d;
	end

	assign decode_done_o = done_q;
	assign ctrl_o        = ctrl_q;

endmodule

//--- source/exec_unit.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module exec_unit import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       decode_done_i,
	input  ctrl_t      ctrl_i,
	output logic       exec_done_o,
	output ex_result_t result_o
);
	logic [`CORE_XLEN-1:0] op_a, op_b;
	logic [`CORE_XLEN-1:0] alu_out;
	logic [`CORE_XLEN-1:0] pc_plus4, br_target, next_pc;
	logic                  taken;
	ex_result_t            res_q;
	logic                  done_q;

	assign op_a = ctrl_i.a_sel_pc ? ctrl_i.pc : ctrl_i.rs1_data;
	assign op_b = ctrl_i.b_sel_imm ? ctrl_i.imm : ctrl_i.rs2_data;

	always_comb begin
		alu_out = '0;
		case (ctrl_i.alu_op)
			ALU_ADD:    alu_out = op_a + op_b;
			ALU_SUB:    alu_out = op_a - op_b;
			ALU_SLL:    alu_out = op_a << op_b[4:0];
			ALU_SLT:    alu_out[0] = $signed(op_a) < $signed(op_b);
			ALU_SLTU:   alu_out[0] = op_a < op_b;
			ALU_XOR:    alu_out = op_a ^ op_b;
			ALU_SRL:    alu_out = op_a >> op_b[4:0];
			ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
			ALU_OR:     alu_out = op_a | op_b;
			ALU_AND:    alu_out = op_a & op_b;
			ALU_PASS_B: alu_out = op_b;
			default:    alu_out = '0;
		endcase
	end

	// branch condition straight from funct3
	always_comb begin
		case (ctrl_i.funct3)
			3'b000:  taken = ctrl_i.rs1_data == ctrl_i.rs2_data;
			3'b001:  taken = ctrl_i.rs1_data != ctrl_i.rs2_data;
			3'b100:  taken = $signed(ctrl_i.rs1_data) < $signed(ctrl_i.rs2_data);
			3'b101:  taken = $signed(ctrl_i.rs1_data) >= $signed(ctrl_i.rs2_data);
			3'b110:  taken = ctrl_i.rs1_data < ctrl_i.rs2_data;
			3'b111:  taken = ctrl_i.rs1_data >= ctrl_i.rs2_data;
			default: taken = 1'b0;
		endcase
	end

	assign pc_plus4  = ctrl_i.pc + `CORE_XLEN'd4;
	assign br_target = ctrl_i.pc + ctrl_i.imm;
	assign next_pc   = ctrl_i.is_jalr ? {alu_out[`CORE_XLEN-1:1], 1'b0}
		: (ctrl_i.is_jal || (ctrl_i.is_branch && taken)) ? br_target
		: pc_plus4;

	always_ff @(posedge clock) begin
		if (reset)
			done_q <= 1'b0;
		else
			done_q <= decode_done_i;
	end

	always_ff @(posedge clock) begin
		if (decode_done_i) begin
			res_q.alu_result <= alu_out;
			res_q.store_data <= ctrl_i.rs2_data;
			res_q.link       <= pc_plus4;
			res_q.next_pc    <= next_pc;
			res_q.is_link    <= ctrl_i.is_jal | ctrl_i.is_jalr;
			res_q.is_load    <= ctrl_i.is_load;
			res_q.is_store   <= ctrl_i.is_store;
			res_q.rd_wen     <= ctrl_i.rd_wen;
			res_q.rd         <= ctrl_i.rd;
		end
	end

	assign exec_done_o = done_q;
	assign result_o    = res_q;

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module fetch_unit import core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  retire_i,
	input  logic [`CORE_XLEN-1:0] next_pc_i,
	output logic                  imem_valid_o,
	output mem_req_t              imem_req_o,
	input  logic                  imem_ready_i,
	input  logic [`CORE_XLEN-1:0] imem_rdata_i,
	output logic                  fetch_done_o,
	output inst_u                 inst_o,
	output logic [`CORE_XLEN-1:0] pc_o
);
	logic                  boot_q; // first cycle out of reset
	logic                  req_q;
	logic                  done_q;
	logic [`CORE_XLEN-1:0] pc_q;
	inst_u                 inst_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			boot_q <= 1'b1;
			req_q  <= 1'b0;
			done_q <= 1'b0;
			pc_q   <= `CORE_RESET_PC;
		end else begin
			boot_q <= 1'b0;
			done_q <= req_q & imem_ready_i;
			if (boot_q || retire_i)
				req_q <= 1'b1;
			else if (imem_ready_i)
				req_q <= 1'b0; // transfer done, drop valid next cycle
			if (retire_i)
				pc_q <= next_pc_i;
		end
	end

	// word held until the next fetch completes
	always_ff @(posedge clock) begin
		if (req_q && imem_ready_i)
			inst_q <= imem_rdata_i;
	end

	assign imem_valid_o = req_q;
	assign imem_req_o   = '{addr: pc_q, wdata: '0, wen: 1'b0};
	assign fetch_done_o = done_q;
	assign inst_o       = inst_q;
	assign pc_o         = pc_q;

endmodule

//--- source/load_store_unit.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module load_store_unit import core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  exec_done_i,
	input  ex_result_t            result_i,
	output logic                  dmem_valid_o,
	output mem_req_t              dmem_req_o,
	input  logic                  dmem_ready_i,
	input  logic [`CORE_XLEN-1:0] dmem_rdata_i,
	output logic                  retire_o,
	output logic [`CORE_XLEN-1:0] next_pc_o,
	output wb_t                   wb_o
);
	logic                  mem_op;
	logic                  req_q;
	logic                  retire_q;
	logic [`CORE_XLEN-1:0] rdata_q;

	assign mem_op = result_i.is_load | result_i.is_store;

	always_ff @(posedge clock) begin
		if (reset) begin
			req_q    <= 1'b0;
			retire_q <= 1'b0;
		end else begin
			retire_q <= (exec_done_i & ~mem_op) | (req_q & dmem_ready_i);
			if (exec_done_i && mem_op)
				req_q <= 1'b1;
			else if (dmem_ready_i)
				req_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req_q && dmem_ready_i)
			rdata_q <= dmem_rdata_i; // load word
	end

	// result_i stays put until the next instruction reaches execute
	assign dmem_valid_o = req_q;
	assign dmem_req_o   = '{addr: result_i.alu_result, wdata: result_i.store_data,
		wen: result_i.is_store};

	always_comb begin
		wb_o.wen = retire_q & result_i.rd_wen;
		wb_o.rd  = result_i.rd;
		if (result_i.is_load)
			wb_o.data = rdata_q;
		else if (result_i.is_link)
			wb_o.data = result_i.link;
		else
			wb_o.data = result_i.alu_result;
	end

	assign retire_o  = retire_q;
	assign next_pc_o = result_i.next_pc;

endmodule

//--- source/reg_file.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module reg_file import core_pkg::*; (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [`CORE_REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [`CORE_REG_ADDR_W-1:0] rs2_addr_i,
	output logic [`CORE_XLEN-1:0]       rs1_data_o,
	output logic [`CORE_XLEN-1:0]       rs2_data_o,
	input  wb_t                         wb_i
);
	logic [`CORE_XLEN-1:0] regs [1:`CORE_NUM_REGS-1]; // no storage for x0

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int n = 1; n < `CORE_NUM_REGS; n++)
				regs[n] <= '0;
		end else if (wb_i.wen && wb_i.rd != '0) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule
